//--- src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int mem_addr_width = 6;
    localparam int mem_depth      = 64;
    localparam int target_width   = 26;   // j instruction index field

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        r_type = 6'h00,
        j      = 6'h02,
        beq    = 6'h04,
        addi   = 6'h08,
        ori    = 6'h0d,
        lw     = 6'h23,
        sw     = 6'h2b
    } opcode_t;

    // r-type function field, instr[5:0]
    typedef enum logic [5:0] {
        f_add = 6'h20,
        f_sub = 6'h22,
        f_and = 6'h24,
        f_or  = 6'h25
    } funct_t;

    // alu_default gives a zero result
    typedef enum logic [2:0] {
        alu_default,
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_t;

endpackage

`default_nettype wire

//--- src/pipe_if.sv
`default_nettype none

// fetch -> decode bundle, flush runs backwards
interface fetch_decode_if;
    import mips_pkg::*;

    logic                  valid;
    logic [word_width-1:0] pc;
    logic [word_width-1:0] instr;
    logic                  flush;

    modport fetch  (output valid, pc, instr, input flush);
    modport decode (input valid, pc, instr, output flush);
endinterface

// registered decode output
interface decode_execute_if;
    import mips_pkg::*;

    logic                      valid;
    logic [word_width-1:0]     pc;
    logic [word_width-1:0]     operand_a;
    logic [word_width-1:0]     operand_b_reg;
    logic [word_width-1:0]     immediate;
    logic [target_width-1:0]   jump_target;
    logic [reg_addr_width-1:0] write_reg;
    logic                      alu_src;
    logic                      mem_to_reg;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      branch;
    logic                      jump;
    alu_op_t                   alu_op;

    modport decode (output valid, pc, operand_a, operand_b_reg, immediate, jump_target,
                    write_reg, alu_src, mem_to_reg, reg_write, mem_read, mem_write,
                    branch, jump, alu_op);
    modport execute (input valid, pc, operand_a, operand_b_reg, immediate, jump_target,
                     write_reg, alu_src, mem_to_reg, reg_write, mem_read, mem_write,
                     branch, jump, alu_op);
endinterface

`default_nettype wire

//--- src/fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                run,
    input  wire                                imem_we,
    input  wire [mips_pkg::mem_addr_width-1:0] imem_addr,
    input  wire [mips_pkg::word_width-1:0]     imem_data,
    input  wire                                redirect,
    input  wire [mips_pkg::word_width-1:0]     redirect_pc,
    fetch_decode_if.fetch                      fd
);
    import mips_pkg::*;

    logic [word_width-1:0] imem [mem_depth];
    logic [word_width-1:0] pc;
    logic [word_width-1:0] fetch_word;

    assign fetch_word = imem[pc[mem_addr_width+1:2]];   // word addressed async read

    // program load port is used while run is low
    always_ff @(posedge clk) begin
        if (imem_we)
            imem[imem_addr] <= imem_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            fd.valid <= 1'b0;
        end else begin
            if (redirect)
                pc <= redirect_pc;          // taken beq or j
            else if (run)
                pc <= pc + 32'd4;
            fd.valid <= run && !fd.flush;   // wrong-path fetch is dropped
        end
    end

    // payload is qualified by fd.valid
    always_ff @(posedge clk) begin
        fd.pc    <= pc;
        fd.instr <= fetch_word;
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                                clk,
    input  wire                                reset,
    input  wire [mips_pkg::reg_addr_width-1:0] rs_addr,
    input  wire [mips_pkg::reg_addr_width-1:0] rt_addr,
    output logic [mips_pkg::word_width-1:0]    rs_data,
    output logic [mips_pkg::word_width-1:0]    rt_data,
    input  wire                                wb_en,
    input  wire [mips_pkg::reg_addr_width-1:0] wb_reg,
    input  wire [mips_pkg::word_width-1:0]     wb_data,
    input  wire [mips_pkg::reg_addr_width-1:0] dbg_reg_addr,
    output logic [mips_pkg::word_width-1:0]    dbg_reg_data
);
    import mips_pkg::*;

    logic [word_width-1:0] regs [32];

    // r0 is hardwired and a same-cycle write is forwarded
    function automatic logic [word_width-1:0] read_port(input logic [reg_addr_width-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wb_en && wb_reg == addr)
            return wb_data;
        else
            return regs[addr];
    endfunction

    always_comb begin
        rs_data      = read_port(rs_addr);
        rt_data      = read_port(rt_addr);
        dbg_reg_data = read_port(dbg_reg_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_en && wb_reg != '0) begin
            regs[wb_reg] <= wb_data;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                                 clk,
    input  wire                                 reset,
    fetch_decode_if.decode                      fd,
    decode_execute_if.decode                    de,
    input  wire                                 redirect,
    output logic [mips_pkg::reg_addr_width-1:0] rs_addr,
    output logic [mips_pkg::reg_addr_width-1:0] rt_addr,
    input  wire [mips_pkg::word_width-1:0]      rs_data,
    input  wire [mips_pkg::word_width-1:0]      rt_data
);
    import mips_pkg::*;

    opcode_t                   opcode;
    funct_t                    funct;
    logic [15:0]               imm16;
    logic [reg_addr_width-1:0] rd_addr;

    logic    reg_dst;
    logic    alu_src;
    logic    mem_to_reg;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    jump;
    alu_op_t alu_op;

    logic [word_width-1:0]     immediate;
    logic [reg_addr_width-1:0] write_reg;

    assign opcode  = opcode_t'(fd.instr[31:26]);
    assign funct   = funct_t'(fd.instr[5:0]);
    assign rs_addr = fd.instr[25:21];
    assign rt_addr = fd.instr[20:16];
    assign rd_addr = fd.instr[15:11];
    assign imm16   = fd.instr[15:0];

    assign fd.flush = redirect;   // wrong path in fetch register

    // control table, anything unlisted retires as a no-op
    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        alu_op     = alu_default;
        case (opcode)
            r_type: begin
                reg_dst   = 1'b1;   // rd
                reg_write = 1'b1;
                case (funct)
                    f_add:   alu_op = alu_add;
                    f_sub:   alu_op = alu_sub;
                    f_and:   alu_op = alu_and;
                    f_or:    alu_op = alu_or;
                    default: alu_op = alu_default;   // unknown funct writes zero
                endcase
            end
            addi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_op    = alu_add;
            end
            ori: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_op    = alu_or;
            end
            beq: begin
                branch = 1'b1;
                alu_op = alu_sub;   // compare by subtraction
            end
            j: jump = 1'b1;
            lw: begin
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                alu_op     = alu_add;   // address calc
            end
            sw: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                alu_op    = alu_add;
            end
            default: ;
        endcase
    end

    assign immediate = (opcode == ori) ? {16'h0000, imm16}
                                       : {{16{imm16[15]}}, imm16};
    assign write_reg = reg_dst ? rd_addr : rt_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            de.valid      <= 1'b0;
            de.alu_src    <= 1'b0;
            de.mem_to_reg <= 1'b0;
            de.reg_write  <= 1'b0;
            de.mem_read   <= 1'b0;
            de.mem_write  <= 1'b0;
            de.branch     <= 1'b0;
            de.jump       <= 1'b0;
            de.alu_op     <= alu_default;
        end else begin
            de.valid      <= fd.valid && !redirect;   // squash on redirect
            de.alu_src    <= alu_src;
            de.mem_to_reg <= mem_to_reg;
            de.reg_write  <= reg_write;
            de.mem_read   <= mem_read;
            de.mem_write  <= mem_write;
            de.branch     <= branch;
            de.jump       <= jump;
            de.alu_op     <= alu_op;
        end
    end

    always_ff @(posedge clk) begin
        de.pc            <= fd.pc;
        de.operand_a     <= rs_data;
        de.operand_b_reg <= rt_data;
        de.immediate     <= immediate;
        de.jump_target   <= fd.instr[target_width-1:0];
        de.write_reg     <= write_reg;
    end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire                                 clk,
    input  wire                                 reset,
    decode_execute_if.execute                   de,
    output logic                                redirect,
    output logic [mips_pkg::word_width-1:0]     redirect_pc,
    output logic                                wb_en,
    output logic [mips_pkg::reg_addr_width-1:0] wb_reg,
    output logic [mips_pkg::word_width-1:0]     wb_data,
    output logic                                halted
);
    import mips_pkg::*;

    logic [word_width-1:0]     dmem [mem_depth];
    logic [word_width-1:0]     alu_b;
    logic [word_width-1:0]     alu_result;
    logic [word_width-1:0]     load_data;
    logic [word_width-1:0]     pc_plus4;
    logic [word_width-1:0]     branch_pc;
    logic [word_width-1:0]     jump_pc;
    logic [mem_addr_width-1:0] dmem_addr;
    logic                      branch_taken;

    assign alu_b = de.alu_src ? de.immediate : de.operand_b_reg;

    always_comb begin
        case (de.alu_op)
            alu_add: alu_result = de.operand_a + alu_b;
            alu_sub: alu_result = de.operand_a - alu_b;
            alu_and: alu_result = de.operand_a & alu_b;
            alu_or:  alu_result = de.operand_a | alu_b;
            default: alu_result = '0;
        endcase
    end

    // branch and jump targets
    assign pc_plus4     = de.pc + 32'd4;
    assign branch_pc    = pc_plus4 + {de.immediate[word_width-3:0], 2'b00};
    assign jump_pc      = {de.pc[31:28], de.jump_target, 2'b00};
    assign branch_taken = de.branch && (alu_result == '0);

    assign redirect    = de.valid && (branch_taken || de.jump);
    assign redirect_pc = de.jump ? jump_pc : branch_pc;

    // data memory, word addressed
    assign dmem_addr = alu_result[mem_addr_width+1:2];
    assign load_data = de.mem_read ? dmem[dmem_addr] : '0;

    always_ff @(posedge clk) begin
        if (de.valid && de.mem_write)
            dmem[dmem_addr] <= de.operand_b_reg;
    end

    // write-back goes straight into reg_file this cycle
    assign wb_en   = de.valid && de.reg_write;
    assign wb_reg  = de.write_reg;
    assign wb_data = de.mem_to_reg ? load_data : alu_result;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset)
            halted <= 1'b0;
        else if (de.valid && de.jump && jump_pc == de.pc)
            halted <= 1'b1;   // self-jump ends the program
    end

endmodule

`default_nettype wire

//--- src/mips_core.sv
`default_nettype none

module mips_core (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                run,
    input  wire                                imem_we,
    input  wire [mips_pkg::mem_addr_width-1:0] imem_addr,
    input  wire [mips_pkg::word_width-1:0]     imem_data,
    input  wire [mips_pkg::reg_addr_width-1:0] dbg_reg_addr,
    output logic [mips_pkg::word_width-1:0]    dbg_reg_data,
    output logic                               halted
);
    import mips_pkg::*;

    logic                      redirect;
    logic [word_width-1:0]     redirect_pc;
    logic [reg_addr_width-1:0] rs_addr;
    logic [reg_addr_width-1:0] rt_addr;
    logic [word_width-1:0]     rs_data;
    logic [word_width-1:0]     rt_data;
    logic                      wb_en;
    logic [reg_addr_width-1:0] wb_reg;
    logic [word_width-1:0]     wb_data;

    fetch_decode_if   u_fd_if ();
    decode_execute_if u_de_if ();

    fetch_stage u_fetch_stage (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fd          (u_fd_if.fetch)
    );

    decode_stage u_decode_stage (
        .clk      (clk),
        .reset    (reset),
        .fd       (u_fd_if.decode),
        .de       (u_de_if.decode),
        .redirect (redirect),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data)
    );

    reg_file u_reg_file (
        .clk          (clk),
        .reset        (reset),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .wb_en        (wb_en),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .reset       (reset),
        .de          (u_de_if.execute),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .halted      (halted)
    );

endmodule

`default_nettype wire

//--- testbench/mips_core_properties.sv
`default_nettype none

module mips_core_properties (
    input wire                                clk,
    input wire                                reset,
    input wire                                halted,
    input wire [mips_pkg::reg_addr_width-1:0] dbg_reg_addr,
    input wire [mips_pkg::word_width-1:0]     dbg_reg_data
);
    timeunit 1ns;
    timeprecision 1ps;

    halted_cleared_by_reset: assert property (@(posedge clk) reset |=> !halted)
        else $error("halted still high the cycle after reset");

    // sticky until the next reset
    halted_sticky: assert property (@(posedge clk) (halted && !reset) |=> halted)
        else $error("halted fell without reset");

    r0_reads_zero: assert property (@(posedge clk)
        (dbg_reg_addr == '0) |-> (dbg_reg_data == '0))
        else $error("debug read of r0 returned a nonzero value");

endmodule

bind mips_core mips_core_properties u_mips_core_properties (
    .clk          (clk),
    .reset        (reset),
    .halted       (halted),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data)
);

`default_nettype wire

//--- testbench/tb_mips_core.sv
`default_nettype none

module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 16;
    localparam int max_tests    = 16;

    logic                      clk;
    logic                      reset;
    logic                      run;
    logic                      imem_we;
    logic [mem_addr_width-1:0] imem_addr;
    logic [word_width-1:0]     imem_data;
    logic [reg_addr_width-1:0] dbg_reg_addr;
    logic [word_width-1:0]     dbg_reg_data;
    logic                      halted;

    // test table, filled from the stim file
    logic [8*32-1:0]       test_name [max_tests];
    int                    prog_base [max_tests];
    int                    prog_len  [max_tests];
    int                    exp_base  [max_tests];
    int                    exp_len   [max_tests];
    logic [word_width-1:0] prog_words [$];
    int                    exp_reg    [$];
    logic [word_width-1:0] exp_val    [$];

    int num_tests    = 0;
    int total_instr  = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit stim_loaded  = 1'b0;
    bit stim_error   = 1'b0;

    mips_core u_mips_core (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic read_stim();
        int                    fd;
        int                    code;
        int                    n_instr;
        int                    n_exp;
        int                    r;
        logic [word_width-1:0] w;
        logic [8*32-1:0]       tok;
        logic [8*32-1:0]       name;
        logic [8*128-1:0]      rest;
        bit                    done;
        fd = $fopen("testbench/core_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/core_stim.txt");
            stim_error = 1'b1;
            return;
        end
        done = 1'b0;
        while (!done) begin
            tok  = '0;
            name = '0;
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;                            // end of file
            end else if (tok == 256'("#")) begin
                code = $fgets(rest, fd);                // skip comment line
            end else if (tok == 256'("test") && num_tests < max_tests) begin
                code = $fscanf(fd, "%s %d %d", name, n_instr, n_exp);
                if (code != 3) begin
                    $display("malformed test header in stim file");
                    stim_error = 1'b1;
                    done = 1'b1;
                end
                test_name[num_tests] = name;
                prog_base[num_tests] = prog_words.size();
                prog_len[num_tests]  = n_instr;
                exp_base[num_tests]  = exp_reg.size();
                exp_len[num_tests]   = n_exp;
                for (int k = 0; k < n_instr; k++) begin
                    code = $fscanf(fd, "%h", w);
                    prog_words.push_back(w);
                end
                for (int k = 0; k < n_exp; k++) begin
                    code = $fscanf(fd, "%d %h", r, w);
                    exp_reg.push_back(r);
                    exp_val.push_back(w);
                end
                total_instr += n_instr;
                num_tests++;
            end else begin
                $display("unexpected entry %0s in stim file or too many tests", tok);
                stim_error = 1'b1;
                done = 1'b1;
            end
        end
        $fclose(fd);
    endtask

    task automatic reset_core();
        reset = 1'b1;
        run   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic load_program(input int t);
        for (int k = 0; k < prog_len[t]; k++) begin
            imem_we   = 1'b1;
            imem_addr = mem_addr_width'(k);
            imem_data = prog_words[prog_base[t] + k];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
    endtask

    task automatic run_to_halt();
        run = 1'b1;
        do
            @(negedge clk);                             // halted is stable here
        while (!halted);
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    task automatic check_registers(input int t, output int mismatches);
        int idx;
        mismatches = 0;
        for (int k = 0; k < exp_len[t]; k++) begin
            idx          = exp_base[t] + k;
            dbg_reg_addr = reg_addr_width'(exp_reg[idx]);
            @(negedge clk);
            if (dbg_reg_data !== exp_val[idx]) begin
                $display("CHECK FAILED %0s r%0d: expected %08h actual %08h",
                         test_name[t], exp_reg[idx], exp_val[idx], dbg_reg_data);
                mismatches++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int mismatches;
        reset        = 1'b1;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_addr = '0;
        read_stim();
        stim_loaded = 1'b1;
        if (!stim_error) begin
            for (int t = 0; t < num_tests; t++) begin
                reset_core();
                load_program(t);
                run_to_halt();
                check_registers(t, mismatches);
                if (mismatches == 0) begin
                    tests_passed++;
                    $display("test %0s: passed", test_name[t]);
                end else begin
                    tests_failed++;
                    $display("test %0s: failed with %0d mismatches", test_name[t], mismatches);
                end
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", num_tests, tests_passed, tests_failed);
        if (!stim_error && num_tests > 0 && tests_failed == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // budget is 4 cycles per instruction plus 50 per test
    initial begin
        int limit_cycles;
        wait (stim_loaded);
        limit_cycles = 4 * total_instr + 50 * num_tests;
        #(limit_cycles * clk_period);
        $display("timeout: tests did not finish within %0d cycles", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/mips_pkg.sv
src/pipe_if.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mips_core.sv
testbench/mips_core_properties.sv
testbench/tb_mips_core.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
TOP        = tb_mips_core
FILELIST   = src.f
OBJ_DIR    = obj_dir
PASS_MSG   = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/core_stim.txt
# test <name> <instruction count> <expected count>, then the instruction words in hex,
# then the expected values as pairs of decimal register number and hex value
# r-type ops on ori/addi values, funct 0x27 is not decoded and writes zero to r7
test alu_ops 10 8
340100f0 20020033 00221820 00222022 00222824
00223025 34070055 00223827 00414022 08000009
1 f0 2 33 3 123 4 bd 5 30 6 f3 7 0 8 ffffff43
# addi sign extends, ori zero extends
test immediates 6 5
2001fffb 34028001 20237fff 3444f000 2045ffff 08000005
1 fffffffb 2 8001 3 7ffa 4 f001 5 8000
# sw then lw, load result used by the next instruction
test load_store 9 6
34011234 20020008 ac410004 8c03000c 00632020
20850001 ac45fffc 8c060004 08000008
1 1234 2 8 3 1234 4 2468 5 2469 6 2469
# taken beq skips r3 and r4, not-taken beq falls through
test branches 10 7
34010005 34020005 10220002 34030011 34040022
34050033 10200002 34060044 34070055 08000009
1 5 2 5 3 0 4 0 5 33 6 44 7 55
# j over two instructions, then self jump
test jumps 6 4
34010077 08000004 34020088 34030099 340400aa 08000005
1 77 2 0 3 0 4 aa
